// ==== common/match_settings.svh ====
`ifndef MATCH_SETTINGS_SVH
`define MATCH_SETTINGS_SVH

// Number of keyword categories, one matcher each
`define NUM_CATEGORIES 4

// Stream identifier width, 64 streams
`define STREAM_ID_W 6

// One character of the reassembled stream
`define CHAR_W 8

// Width of the per-category hit counters and the alert total
`define COUNT_W 16

// Longest keyword in characters
// Also the width of the automaton progress vector
`define KEY_MAX 8

`endif

// ==== common/match_pkg.sv ====
`include "match_settings.svh"

package match_pkg;

   // Plain vectors with a meaning of their own
   typedef logic [`CHAR_W-1:0]         char_t;
   typedef logic [`STREAM_ID_W-1:0]    stream_id_t;
   typedef logic [`NUM_CATEGORIES-1:0] cat_mask_t;
   typedef logic [`KEY_MAX-1:0]        auto_state_t;
   typedef logic [`COUNT_W-1:0]        hit_count_t;

   // Keyword text, right aligned as a string literal
   // The last keyword character sits in bits [7:0]
   typedef logic [`KEY_MAX*`CHAR_W-1:0] key_text_t;

   // One input beat of the packet stream
   typedef struct packed {
      logic       sop;
      logic       eop;
      logic       char_vld;
      char_t      ch;
      stream_id_t stream_id;
   } pkt_beat_t;

   // Tracker output, broadcast to every matcher and the collector
   typedef struct packed {
      logic       load_state;
      logic       new_stream;
      logic       eop;
      logic       char_vld;
      char_t      ch;
      stream_id_t stream_id;
      cat_mask_t  enable;
   } lane_ctrl_t;

   // One alert per packet that hit at least one category
   typedef struct packed {
      logic       vld;
      stream_id_t stream_id;
      cat_mask_t  cat_mask;
   } alert_t;

   // Keyword table, one literal per category
   localparam key_text_t KEYWORDS [`NUM_CATEGORIES] = '{"login", "passwd", "root", "shell"};
   localparam int KEY_LENS [`NUM_CATEGORIES] = '{5, 6, 4, 5};

endpackage

// ==== source/stream_tracker.sv ====
`timescale 1ns/100ps
`include "match_settings.svh"

module stream_tracker
   import match_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  pkt_beat_t  beat,
   input  logic       cfg_we,
   input  stream_id_t cfg_stream_id,
   input  cat_mask_t  cfg_mask,
   output lane_ctrl_t lane
);

   localparam int NUM_STREAMS = 1 << `STREAM_ID_W;

   // One bit per stream, set once the stream has had a sop
   logic [NUM_STREAMS-1:0] seen;

   // Per-stream category enables, written by the config port
   cat_mask_t enable_tbl [NUM_STREAMS];

   // Seen bitmap
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         seen <= '0;
      end
      else if (beat.sop)
      begin
         seen[beat.stream_id] <= 1'b1;
      end
   end

   // Enable table
   // A write in the same cycle as a sop only shows up for later sops
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int s = 0; s < NUM_STREAMS; s++)
         begin
            enable_tbl[s] <= '0;
         end
      end
      else if (cfg_we)
      begin
         enable_tbl[cfg_stream_id] <= cfg_mask;
      end
   end

   // Lane register, one cycle behind the input beat
   always_ff @(posedge clk)
   begin
      // Payload follows the beat every cycle
      lane.ch        <= beat.ch;
      lane.stream_id <= beat.stream_id;
      // Only meaningful together with load_state
      lane.new_stream <= !seen[beat.stream_id];

      if (!rst_n)
      begin
         lane.load_state <= 1'b0;
         lane.eop        <= 1'b0;
         lane.char_vld   <= 1'b0;
         lane.enable     <= '0;
      end
      else
      begin
         // Start of packet triggers the state restore in every matcher
         lane.load_state <= beat.sop;
         lane.eop        <= beat.eop;
         lane.char_vld   <= beat.char_vld;

         // Mask is latched at sop and held to the end of the packet
         if (beat.sop)
         begin
            lane.enable <= enable_tbl[beat.stream_id];
         end
      end
   end

endmodule

// ==== category_match/keyword_automaton.sv ====
`timescale 1ns/100ps
`include "match_settings.svh"

module keyword_automaton
   import match_pkg::*;
#(
   parameter key_text_t KEYWORD = '0,
   parameter int        KEY_LEN = 1
)
(
   input  logic        clk,
   input  logic        rst_n,
   input  char_t       char_in,
   input  logic        char_in_vld,
   input  auto_state_t state_in,
   input  logic        state_in_vld,
   output auto_state_t state_out,
   output logic        accept_out
);

   // Per-position compare of the current character with the keyword
   auto_state_t key_hit;
   // Progress vector and its next value after one character
   auto_state_t state_q;
   auto_state_t step;

   // Keyword character k sits at byte KEY_LEN-1-k of the text
   for (genvar k = 0; k < `KEY_MAX; k++)
   begin : g_pos
      if (k < KEY_LEN)
      begin : g_used
         assign key_hit[k] = (char_in == KEYWORD[(KEY_LEN-1-k)*`CHAR_W +: `CHAR_W]);
      end
      else
      begin : g_unused
         // Positions past the keyword never match
         assign key_hit[k] = 1'b0;
      end
   end

   // Shift-and step, a new attempt starts at every character
   assign step = {state_q[`KEY_MAX-2:0], 1'b1} & key_hit;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q    <= '0;
         accept_out <= 1'b0;
      end
      else
      begin
         accept_out <= 1'b0;
         // A restore wins over a character
         if (state_in_vld)
         begin
            state_q <= state_in;
         end
         else if (char_in_vld)
         begin
            state_q    <= step;
            // Full keyword seen ending at this character
            accept_out <= step[KEY_LEN-1];
         end
      end
   end

   assign state_out = state_q;

endmodule

// ==== category_match/category_match.sv ====
`timescale 1ns/100ps
`include "match_settings.svh"

module category_match
   import match_pkg::*;
#(
   parameter int CAT_INDEX = 0
)
(
   input  logic       clk,
   input  logic       rst_n,
   input  lane_ctrl_t lane,
   output hit_count_t count,
   output logic       fired
);

   localparam int NUM_STREAMS = 1 << `STREAM_ID_W;

   // Saved automaton progress, one entry per stream
   auto_state_t state_mem [NUM_STREAMS];

   // Restore path into the automaton
   auto_state_t state_in;
   logic        state_in_vld;

   // Automaton outputs
   auto_state_t state_out;
   logic        accept_out;

   // Set by any keyword hit in the current packet
   logic spec_match;
   // This category is switched on for the current stream
   logic enabled;

   assign enabled = lane.enable[CAT_INDEX];
   assign fired   = spec_match;

   // Match flag and packet hit counter
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         count      <= '0;
         spec_match <= 1'b0;
      end
      else
      begin
         // New packet, forget the previous result
         if (lane.load_state)
         begin
            spec_match <= 1'b0;
         end

         if (accept_out)
         begin
            spec_match <= 1'b1;
         end

         // Commit the packet result at eop
         if (lane.eop)
         begin
            if (enabled)
            begin
               count <= count + hit_count_t'(spec_match);
            end
            else
            begin
               // Disabled, the hit does not count and is not reported
               spec_match <= 1'b0;
            end
         end
      end
   end

   // Save progress at an enabled eop
   // A disabled packet leaves the stored state untouched
   always_ff @(posedge clk)
   begin
      if (lane.eop && enabled)
      begin
         state_mem[lane.stream_id] <= state_out;
      end
   end

   // Restore one cycle after load_state, zero for an unseen stream
   always_ff @(posedge clk)
   begin
      if (lane.load_state)
      begin
         state_in <= lane.new_stream ? '0 : state_mem[lane.stream_id];
      end

      if (!rst_n)
      begin
         state_in_vld <= 1'b0;
      end
      else
      begin
         state_in_vld <= lane.load_state;
      end
   end

   keyword_automaton #(
      .KEYWORD (KEYWORDS[CAT_INDEX]),
      .KEY_LEN (KEY_LENS[CAT_INDEX])
   ) u_automaton (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_in      (lane.ch),
      .char_in_vld  (lane.char_vld),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept_out   (accept_out)
   );

endmodule

// ==== source/alert_collector.sv ====
`timescale 1ns/100ps

module alert_collector
   import match_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  lane_ctrl_t lane,
   input  cat_mask_t  fired,
   output alert_t     alert,
   output hit_count_t alert_total
);

   // Tracker eop and stream id, one cycle later
   // By then the matchers have settled their flags
   logic       eop_d;
   stream_id_t stream_id_d;

   // Categories that are enabled and hit in this packet
   cat_mask_t hit_mask;
   logic      any_hit;

   // Enable mask is still held, the next sop is at least two cycles away
   assign hit_mask = fired & lane.enable;
   assign any_hit  = eop_d && (hit_mask != '0);

   always_ff @(posedge clk)
   begin
      stream_id_d     <= lane.stream_id;
      alert.stream_id <= stream_id_d;
      alert.cat_mask  <= hit_mask;

      if (!rst_n)
      begin
         eop_d       <= 1'b0;
         alert.vld   <= 1'b0;
         alert_total <= '0;
      end
      else
      begin
         eop_d     <= lane.eop;
         // One pulse per packet, none for an empty mask
         alert.vld <= any_hit;

         if (any_hit)
         begin
            alert_total <= alert_total + 1'b1;
         end
      end
   end

endmodule

// ==== source/match_engine_top.sv ====
`timescale 1ns/100ps
`include "match_settings.svh"

module match_engine_top
   import match_pkg::*;
(
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  pkt_beat_t                              beat,
   input  logic                                   cfg_we,
   input  stream_id_t                             cfg_stream_id,
   input  cat_mask_t                              cfg_mask,
   output alert_t                                 alert,
   output hit_count_t                             alert_total,
   output hit_count_t [`NUM_CATEGORIES-1:0]       counts
);

   // Broadcast control from the tracker
   lane_ctrl_t lane;
   // One fired level per matcher
   cat_mask_t  fired_mask;

   stream_tracker u_tracker (
      .clk           (clk),
      .rst_n         (rst_n),
      .beat          (beat),
      .cfg_we        (cfg_we),
      .cfg_stream_id (cfg_stream_id),
      .cfg_mask      (cfg_mask),
      .lane          (lane)
   );

   // One matcher per keyword category
   for (genvar c = 0; c < `NUM_CATEGORIES; c++)
   begin : g_cat
      category_match #(
         .CAT_INDEX (c)
      ) u_cat (
         .clk   (clk),
         .rst_n (rst_n),
         .lane  (lane),
         .count (counts[c]),
         .fired (fired_mask[c])
      );
   end

   alert_collector u_collector (
      .clk         (clk),
      .rst_n       (rst_n),
      .lane        (lane),
      .fired       (fired_mask),
      .alert       (alert),
      .alert_total (alert_total)
   );

endmodule

// ==== bench/match_model.svh ====
`ifndef MATCH_MODEL_SVH
`define MATCH_MODEL_SVH

localparam int NUM_STREAMS = 1 << `STREAM_ID_W;

// Keyword text per category, in category order
string key_text [`NUM_CATEGORIES] = '{"login", "passwd", "root", "shell"};

// Newest characters of each stream history, per category
// A keyword that ends in the next packet starts at most KEY_MAX-1 characters back
char_t tail_buf [NUM_STREAMS][`NUM_CATEGORIES][`KEY_MAX];
int    tail_len [NUM_STREAMS][`NUM_CATEGORIES];
logic  stream_used [NUM_STREAMS];

// Expected packet hit counts and number of nonempty alerts
int fire_count [`NUM_CATEGORIES];
int exp_alerts;

task automatic model_reset();
   int s;
   int c;
   for (s = 0; s < NUM_STREAMS; s++)
   begin
      stream_used[s] = 1'b0;
      for (c = 0; c < `NUM_CATEGORIES; c++)
      begin
         tail_len[s][c] = 0;
      end
   end
   for (c = 0; c < `NUM_CATEGORIES; c++)
   begin
      fire_count[c] = 0;
   end
   exp_alerts = 0;
endtask

// Runs the packet in pkt_chars through the history of one stream
// Returns the categories with a keyword occurrence ending inside the packet
task automatic model_packet(input stream_id_t sid, input cat_mask_t en,
                            output cat_mask_t fired);
   char_t text [`KEY_MAX + MAX_CHARS];
   int    c;
   int    i;
   int    e;
   int    j;
   int    tl;
   int    total;
   int    klen;
   int    keep;
   logic  match;
   fired = '0;
   for (c = 0; c < `NUM_CATEGORIES; c++)
   begin
      // Disabled categories neither see nor remember this packet
      if (en[c])
      begin
         tl = tail_len[sid][c];
         for (i = 0; i < tl; i++)
         begin
            text[i] = tail_buf[sid][c][i];
         end
         for (i = 0; i < pkt_len; i++)
         begin
            text[tl + i] = pkt_chars[i];
         end
         total = tl + pkt_len;
         klen  = key_text[c].len();
         // Only end positions inside the new packet count
         for (e = tl; e < total; e++)
         begin
            if (e + 1 >= klen)
            begin
               match = 1'b1;
               for (j = 0; j < klen; j++)
               begin
                  if (text[e - klen + 1 + j] != key_text[c][j])
                  begin
                     match = 1'b0;
                  end
               end
               if (match)
               begin
                  fired[c] = 1'b1;
               end
            end
         end
         keep = (total < `KEY_MAX - 1) ? total : `KEY_MAX - 1;
         for (i = 0; i < keep; i++)
         begin
            tail_buf[sid][c][i] = text[total - keep + i];
         end
         tail_len[sid][c] = keep;
      end
      if (fired[c])
      begin
         fire_count[c]++;
      end
   end
   if (fired != '0)
   begin
      exp_alerts++;
   end
   stream_used[sid] = 1'b1;
endtask

`endif

// ==== bench/match_engine_tb.sv ====
`timescale 1ns/100ps
`include "match_settings.svh"

module match_engine_tb
   import match_pkg::*;
();

   localparam int MAX_CHARS    = 16;
   localparam int NUM_RANDOM   = 300;
   localparam int NUM_DIRECTED = 10;
   // sop, gaps, characters with gaps, eop, alert window and config writes
   localparam int MAX_PKT_CYCLES = 72;
   localparam int WATCHDOG_NS = (NUM_RANDOM + NUM_DIRECTED) * MAX_PKT_CYCLES * 10 + 2000;

   logic                             clk = 1'b0;
   logic                             rst_n;
   pkt_beat_t                        beat;
   logic                             cfg_we;
   stream_id_t                       cfg_stream_id;
   cat_mask_t                        cfg_mask;
   alert_t                           alert;
   hit_count_t                       alert_total;
   hit_count_t [`NUM_CATEGORIES-1:0] counts;

   int        seed = 56;
   int        checks;
   int        errors;
   int        tests_run;
   int        tests_failed;
   int        mon_alerts;
   // Characters of the packet being sent
   char_t     pkt_chars [MAX_CHARS];
   int        pkt_len;
   // Copy of the DUT enable table
   cat_mask_t enable_shadow [1 << `STREAM_ID_W];
   // Letters that occur in the keywords
   string     letters = "loginpaswdrthe";

   `include "match_model.svh"

   match_engine_top dut (
      .clk           (clk),
      .rst_n         (rst_n),
      .beat          (beat),
      .cfg_we        (cfg_we),
      .cfg_stream_id (cfg_stream_id),
      .cfg_mask      (cfg_mask),
      .alert         (alert),
      .alert_total   (alert_total),
      .counts        (counts)
   );

   always #5 clk = ~clk;

   // Counts every alert pulse including any outside a packet window
   always @(negedge clk)
   begin
      if (rst_n && alert.vld)
      begin
         mon_alerts++;
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
      $display("Testbench failed");
      $finish;
   end

   function automatic int rnd(input int range);
      int r;
      r = $random(seed);
      return (r & 32'h7fff_ffff) % range;
   endfunction

   function automatic pkt_beat_t make_beat(input logic sop, input logic eop,
                                           input logic vld, input char_t ch,
                                           input stream_id_t sid);
      pkt_beat_t b;
      b.sop       = sop;
      b.eop       = eop;
      b.char_vld  = vld;
      b.ch        = ch;
      b.stream_id = sid;
      return b;
   endfunction

   task automatic check_value(input int actual, input int expected, input string what);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("CHECK FAILED at %0d ns: %s, got 'h%0h, expected 'h%0h",
                  $time, what, actual, expected);
      end
   endtask

   task automatic finish_test(input int num, input string name, input int err_mark);
      tests_run++;
      if (errors > err_mark)
      begin
         tests_failed++;
         $display("Test %0d %s: FAILED with %0d errors", num, name, errors - err_mark);
      end
      else
      begin
         $display("Test %0d %s: ok", num, name);
      end
   endtask

   task automatic idle_cycle(input stream_id_t sid);
      @(posedge clk);
      beat <= make_beat(1'b0, 1'b0, 1'b0, '0, sid);
   endtask

   // Table write that takes effect for later sops only
   task automatic write_enable(input stream_id_t sid, input cat_mask_t mask);
      @(posedge clk);
      cfg_we        <= 1'b1;
      cfg_stream_id <= sid;
      cfg_mask      <= mask;
      @(posedge clk);
      cfg_we <= 1'b0;
      enable_shadow[sid] = mask;
   endtask

   task automatic load_text(input string s);
      int i;
      pkt_len = s.len();
      for (i = 0; i < pkt_len; i++)
      begin
         pkt_chars[i] = s[i];
      end
   endtask

   // Mix of whole keywords, keyword heads, keyword tails and single letters
   task automatic build_random_packet();
      int target;
      int kind;
      int k;
      int first;
      int last;
      int j;
      target  = 1 + rnd(MAX_CHARS - 4);
      pkt_len = 0;
      while (pkt_len < target)
      begin
         kind = rnd(5);
         k    = rnd(`NUM_CATEGORIES);
         if (kind < 3)
         begin
            first = (kind == 1) ? rnd(key_text[k].len()) : 0;
            last  = (kind == 2) ? rnd(key_text[k].len()) : key_text[k].len() - 1;
            for (j = first; j <= last && pkt_len < MAX_CHARS; j++)
            begin
               pkt_chars[pkt_len] = key_text[k][j];
               pkt_len++;
            end
         end
         else
         begin
            pkt_chars[pkt_len] = letters[rnd(letters.len())];
            pkt_len++;
         end
      end
   endtask

   // Sends pkt_chars as one packet and checks the alert window after eop
   task automatic send_packet(input stream_id_t sid, output cat_mask_t dut_mask);
      cat_mask_t exp_mask;
      int        n_pulses;
      int        pulse_at;
      int        gap;
      int        i;
      int        c;
      model_packet(sid, enable_shadow[sid], exp_mask);
      @(posedge clk);
      beat <= make_beat(1'b1, 1'b0, 1'b0, '0, sid);
      // At least one idle cycle after sop and before eop
      gap = 1 + rnd(2);
      repeat (gap) idle_cycle(sid);
      for (i = 0; i < pkt_len; i++)
      begin
         @(posedge clk);
         beat <= make_beat(1'b0, 1'b0, 1'b1, pkt_chars[i], sid);
         gap = rnd(3);
         repeat (gap) idle_cycle(sid);
      end
      gap = 1 + rnd(2);
      repeat (gap) idle_cycle(sid);
      @(posedge clk);
      beat <= make_beat(1'b0, 1'b1, 1'b0, '0, sid);
      n_pulses = 0;
      pulse_at = -1;
      dut_mask = '0;
      // Alert due at the fourth falling edge after the eop is driven
      // Idle beats after eop carry another stream id
      for (i = 0; i < 6; i++)
      begin
         @(negedge clk);
         if (alert.vld)
         begin
            n_pulses++;
            pulse_at = i;
            dut_mask = alert.cat_mask;
            check_value(alert.stream_id, sid, "alert stream id");
         end
         if (i == 3)
         begin
            for (c = 0; c < `NUM_CATEGORIES; c++)
            begin
               check_value(counts[c], fire_count[c], $sformatf("hit count, category %0d", c));
            end
            check_value(alert_total, exp_alerts, "alert total");
         end
         idle_cycle(~sid);
      end
      check_value(n_pulses, (exp_mask != '0) ? 1 : 0, "alert pulses for one packet");
      if (exp_mask != '0)
      begin
         check_value(pulse_at, 3, "alert delay after eop");
      end
      check_value(dut_mask, exp_mask, $sformatf("alert mask, stream %0d", sid));
   endtask

   initial
   begin
      cat_mask_t  got;
      stream_id_t sid;
      int         err_mark;
      int         idx;
      int         c;
      rst_n         = 1'b0;
      beat          = '0;
      cfg_we        = 1'b0;
      cfg_stream_id = '0;
      cfg_mask      = '0;
      checks        = 0;
      errors        = 0;
      tests_run     = 0;
      tests_failed  = 0;
      mon_alerts    = 0;
      model_reset();
      for (idx = 0; idx < (1 << `STREAM_ID_W); idx++)
      begin
         enable_shadow[idx] = '0;
      end
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;

      // Quiet outputs with idle beats
      err_mark = errors;
      repeat (20)
      begin
         @(negedge clk);
         check_value(alert.vld, 0, "alert valid while idle");
         check_value(alert_total, 0, "alert total while idle");
         for (c = 0; c < `NUM_CATEGORIES; c++)
         begin
            check_value(counts[c], 0, $sformatf("hit count while idle, category %0d", c));
         end
      end
      finish_test(1, "idle after reset", err_mark);

      // Fresh streams with all categories on
      err_mark = errors;
      for (idx = 1; idx <= 4; idx++)
      begin
         write_enable(stream_id_t'(idx), 4'hf);
      end
      load_text("login");
      send_packet(6'd1, got);
      check_value(got, 4'b0001, "login packet");
      load_text("apasswd");
      send_packet(6'd2, got);
      check_value(got, 4'b0010, "passwd packet");
      load_text("rootshell");
      send_packet(6'd3, got);
      check_value(got, 4'b1100, "root and shell packet");
      load_text("dog");
      send_packet(6'd4, got);
      check_value(got, 4'b0000, "packet without keyword");
      finish_test(2, "single packet detection", err_mark);

      // passwd split over two packets with another stream in between
      err_mark = errors;
      write_enable(6'd10, 4'hf);
      write_enable(6'd11, 4'hf);
      load_text("gopas");
      send_packet(6'd10, got);
      check_value(got, 4'b0000, "first half of split keyword");
      load_text("root");
      send_packet(6'd11, got);
      check_value(got, 4'b0100, "interleaved stream");
      load_text("swdl");
      send_packet(6'd10, got);
      check_value(got, 4'b0010, "second half of split keyword");
      finish_test(3, "cross packet state", err_mark);

      // shell head is saved and shell is off for one packet before it resumes
      err_mark = errors;
      write_enable(6'd20, 4'hf);
      load_text("sh");
      send_packet(6'd20, got);
      check_value(got, 4'b0000, "shell head");
      write_enable(6'd20, 4'b0111);
      load_text("elllogin");
      send_packet(6'd20, got);
      check_value(got, 4'b0001, "shell disabled");
      write_enable(6'd20, 4'hf);
      load_text("ell");
      send_packet(6'd20, got);
      check_value(got, 4'b1000, "shell resumed");
      finish_test(4, "enable table", err_mark);

      // Random packets over 8 streams
      err_mark = errors;
      for (idx = 0; idx < NUM_RANDOM; idx++)
      begin
         sid = stream_id_t'(rnd(8) * 8 + 5);
         // First packet of a stream runs with every category on
         if (!stream_used[sid])
         begin
            write_enable(sid, 4'hf);
         end
         else if (rnd(8) == 0)
         begin
            write_enable(sid, cat_mask_t'(rnd(16)));
         end
         build_random_packet();
         send_packet(sid, got);
      end
      for (c = 0; c < `NUM_CATEGORIES; c++)
      begin
         check_value(counts[c], fire_count[c], $sformatf("final hit count, category %0d", c));
      end
      check_value(alert_total, exp_alerts, "final alert total");
      check_value(mon_alerts, exp_alerts, "alert pulses over the run");
      finish_test(5, "random packets", err_mark);

      $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
      begin
         $display("Testbench passed");
      end
      else
      begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+common
+incdir+bench
common/match_pkg.sv
source/stream_tracker.sv
category_match/keyword_automaton.sv
category_match/category_match.sv
source/alert_collector.sv
source/match_engine_top.sv
bench/match_engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the match engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module match_engine_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vmatch_engine_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
